//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // widths with a meaning on the bus
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // timer window in the address map
  localparam addr_t       CLINT_BASE   = 32'h0200_0000;
  localparam addr_t       CLINT_MASK   = 32'hffff_0000;
  localparam logic [15:0] MTIME_OFFSET = 16'hbff8;

  // single beat read request
  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } rd_rsp_t;

  // address and data merged, one beat only
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_req_t;

  typedef struct packed {
    resp_t resp;
  } wr_rsp_t;

  // owner of the shared bus
  typedef enum logic [1:0] {
    arb_idle,
    arb_inst_read,
    arb_data_read,
    arb_data_write
  } arb_state_t;

endpackage

`default_nettype wire

//--- design/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
  input  wire logic              clock,
  input  wire logic              reset,
  // instruction port
  input  wire bus_pkg::rd_req_t  inst_rd_req_i,
  input  wire logic              inst_rd_valid_i,
  output logic                   inst_rd_ready_o,
  output bus_pkg::rd_rsp_t       inst_rd_rsp_o,
  output logic                   inst_rd_rsp_valid_o,
  input  wire logic              inst_rd_rsp_ready_i,
  // data port
  input  wire bus_pkg::rd_req_t  data_rd_req_i,
  input  wire logic              data_rd_valid_i,
  output logic                   data_rd_ready_o,
  output bus_pkg::rd_rsp_t       data_rd_rsp_o,
  output logic                   data_rd_rsp_valid_o,
  input  wire logic              data_rd_rsp_ready_i,
  input  wire bus_pkg::wr_req_t  data_wr_req_i,
  input  wire logic              data_wr_valid_i,
  output logic                   data_wr_ready_o,
  output bus_pkg::wr_rsp_t       data_wr_rsp_o,
  output logic                   data_wr_rsp_valid_o,
  input  wire logic              data_wr_rsp_ready_i,
  // shared bus toward the crossbar
  output bus_pkg::rd_req_t       bus_rd_req_o,
  output logic                   bus_rd_valid_o,
  input  wire logic              bus_rd_ready_i,
  input  wire bus_pkg::rd_rsp_t  bus_rd_rsp_i,
  input  wire logic              bus_rd_rsp_valid_i,
  output logic                   bus_rd_rsp_ready_o,
  output bus_pkg::wr_req_t       bus_wr_req_o,
  output logic                   bus_wr_valid_o,
  input  wire logic              bus_wr_ready_i,
  input  wire bus_pkg::wr_rsp_t  bus_wr_rsp_i,
  input  wire logic              bus_wr_rsp_valid_i,
  output logic                   bus_wr_rsp_ready_o
);

  bus_pkg::arb_state_t state_q;
  bus_pkg::arb_state_t hold_q;
  bus_pkg::arb_state_t grant;
  logic                idle;
  logic                req_fire;
  logic                rd_rsp_fire;
  logic                wr_rsp_fire;

  assign idle = (state_q == bus_pkg::arb_idle);

  // fixed priority, but a request already on the bus keeps its slot
  always_comb begin
    if (hold_q != bus_pkg::arb_idle) begin
      grant = hold_q;
    end else if (data_wr_valid_i) begin
      grant = bus_pkg::arb_data_write;
    end else if (data_rd_valid_i) begin
      grant = bus_pkg::arb_data_read;
    end else if (inst_rd_valid_i) begin
      grant = bus_pkg::arb_inst_read;
    end else begin
      grant = bus_pkg::arb_idle;
    end
  end

  // request side
  assign bus_rd_req_o   = (grant == bus_pkg::arb_data_read) ? data_rd_req_i : inst_rd_req_i;
  assign bus_rd_valid_o = idle && (grant == bus_pkg::arb_data_read ||
                                   grant == bus_pkg::arb_inst_read);
  assign bus_wr_req_o   = data_wr_req_i;
  assign bus_wr_valid_o = idle && (grant == bus_pkg::arb_data_write);

  assign inst_rd_ready_o = idle && (grant == bus_pkg::arb_inst_read) && bus_rd_ready_i;
  assign data_rd_ready_o = idle && (grant == bus_pkg::arb_data_read) && bus_rd_ready_i;
  assign data_wr_ready_o = idle && (grant == bus_pkg::arb_data_write) && bus_wr_ready_i;

  assign req_fire = (bus_rd_valid_o && bus_rd_ready_i) || (bus_wr_valid_o && bus_wr_ready_i);

  // response side goes back to the owner only
  assign inst_rd_rsp_o       = bus_rd_rsp_i;
  assign data_rd_rsp_o       = bus_rd_rsp_i;
  assign inst_rd_rsp_valid_o = (state_q == bus_pkg::arb_inst_read) && bus_rd_rsp_valid_i;
  assign data_rd_rsp_valid_o = (state_q == bus_pkg::arb_data_read) && bus_rd_rsp_valid_i;
  assign bus_rd_rsp_ready_o  = ((state_q == bus_pkg::arb_inst_read) && inst_rd_rsp_ready_i) ||
                               ((state_q == bus_pkg::arb_data_read) && data_rd_rsp_ready_i);

  assign data_wr_rsp_o       = bus_wr_rsp_i;
  assign data_wr_rsp_valid_o = (state_q == bus_pkg::arb_data_write) && bus_wr_rsp_valid_i;
  assign bus_wr_rsp_ready_o  = (state_q == bus_pkg::arb_data_write) && data_wr_rsp_ready_i;

  assign rd_rsp_fire = bus_rd_rsp_valid_i && bus_rd_rsp_ready_o;
  assign wr_rsp_fire = bus_wr_rsp_valid_i && bus_wr_rsp_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= bus_pkg::arb_idle;
      hold_q  <= bus_pkg::arb_idle;
    end else begin
      case (state_q)
        bus_pkg::arb_idle: begin
          if (req_fire) begin
            state_q <= grant;
          end
        end
        bus_pkg::arb_data_write: begin
          if (wr_rsp_fire) begin
            state_q <= bus_pkg::arb_idle;
          end
        end
        default: begin
          if (rd_rsp_fire) begin
            state_q <= bus_pkg::arb_idle;
          end
        end
      endcase
      // presented but not yet taken
      if (idle && grant != bus_pkg::arb_idle && !req_fire) begin
        hold_q <= grant;
      end else begin
        hold_q <= bus_pkg::arb_idle;
      end
    end
  end

  a_one_read_owner : assert property (@(posedge clock) disable iff (reset)
    !(inst_rd_rsp_valid_o && data_rd_rsp_valid_o));

endmodule

`default_nettype wire

//--- design/bus_xbar.sv
`default_nettype none

module bus_xbar (
  input  wire logic              clock,
  input  wire logic              reset,
  // from the arbiter
  input  wire bus_pkg::rd_req_t  bus_rd_req_i,
  input  wire logic              bus_rd_valid_i,
  output logic                   bus_rd_ready_o,
  output bus_pkg::rd_rsp_t       bus_rd_rsp_o,
  output logic                   bus_rd_rsp_valid_o,
  input  wire logic              bus_rd_rsp_ready_i,
  input  wire bus_pkg::wr_req_t  bus_wr_req_i,
  input  wire logic              bus_wr_valid_i,
  output logic                   bus_wr_ready_o,
  output bus_pkg::wr_rsp_t       bus_wr_rsp_o,
  output logic                   bus_wr_rsp_valid_o,
  input  wire logic              bus_wr_rsp_ready_i,
  // timer side
  output bus_pkg::rd_req_t       clint_rd_req_o,
  output logic                   clint_rd_valid_o,
  input  wire logic              clint_rd_ready_i,
  input  wire bus_pkg::rd_rsp_t  clint_rd_rsp_i,
  input  wire logic              clint_rd_rsp_valid_i,
  output logic                   clint_rd_rsp_ready_o,
  output bus_pkg::wr_req_t       clint_wr_req_o,
  output logic                   clint_wr_valid_o,
  input  wire logic              clint_wr_ready_i,
  input  wire bus_pkg::wr_rsp_t  clint_wr_rsp_i,
  input  wire logic              clint_wr_rsp_valid_i,
  output logic                   clint_wr_rsp_ready_o,
  // external master port
  output bus_pkg::rd_req_t       ext_rd_req_o,
  output logic                   ext_rd_valid_o,
  input  wire logic              ext_rd_ready_i,
  input  wire bus_pkg::rd_rsp_t  ext_rd_rsp_i,
  input  wire logic              ext_rd_rsp_valid_i,
  output logic                   ext_rd_rsp_ready_o,
  output bus_pkg::wr_req_t       ext_wr_req_o,
  output logic                   ext_wr_valid_o,
  input  wire logic              ext_wr_ready_i,
  input  wire bus_pkg::wr_rsp_t  ext_wr_rsp_i,
  input  wire logic              ext_wr_rsp_valid_i,
  output logic                   ext_wr_rsp_ready_o
);

  logic rd_sel_clint;
  logic wr_sel_clint;
  logic rd_pend_q;
  logic wr_pend_q;
  logic rd_clint_q;
  logic wr_clint_q;
  logic rd_fire;
  logic wr_fire;
  logic rd_rsp_fire;
  logic wr_rsp_fire;

  assign rd_sel_clint = (bus_rd_req_i.addr & bus_pkg::CLINT_MASK) == bus_pkg::CLINT_BASE;
  assign wr_sel_clint = (bus_wr_req_i.addr & bus_pkg::CLINT_MASK) == bus_pkg::CLINT_BASE;

  // payload fans out, valid only to the decoded target
  assign clint_rd_req_o   = bus_rd_req_i;
  assign ext_rd_req_o     = bus_rd_req_i;
  assign clint_rd_valid_o = bus_rd_valid_i && !rd_pend_q && rd_sel_clint;
  assign ext_rd_valid_o   = bus_rd_valid_i && !rd_pend_q && !rd_sel_clint;
  assign bus_rd_ready_o   = !rd_pend_q && (rd_sel_clint ? clint_rd_ready_i : ext_rd_ready_i);
  assign rd_fire          = bus_rd_valid_i && bus_rd_ready_o;

  assign clint_wr_req_o   = bus_wr_req_i;
  assign ext_wr_req_o     = bus_wr_req_i;
  assign clint_wr_valid_o = bus_wr_valid_i && !wr_pend_q && wr_sel_clint;
  assign ext_wr_valid_o   = bus_wr_valid_i && !wr_pend_q && !wr_sel_clint;
  assign bus_wr_ready_o   = !wr_pend_q && (wr_sel_clint ? clint_wr_ready_i : ext_wr_ready_i);
  assign wr_fire          = bus_wr_valid_i && bus_wr_ready_o;

  // responses come from the registered target
  assign bus_rd_rsp_o         = rd_clint_q ? clint_rd_rsp_i : ext_rd_rsp_i;
  assign bus_rd_rsp_valid_o   = rd_pend_q &&
                                (rd_clint_q ? clint_rd_rsp_valid_i : ext_rd_rsp_valid_i);
  assign clint_rd_rsp_ready_o = rd_pend_q && rd_clint_q && bus_rd_rsp_ready_i;
  assign ext_rd_rsp_ready_o   = rd_pend_q && !rd_clint_q && bus_rd_rsp_ready_i;
  assign rd_rsp_fire          = bus_rd_rsp_valid_o && bus_rd_rsp_ready_i;

  assign bus_wr_rsp_o         = wr_clint_q ? clint_wr_rsp_i : ext_wr_rsp_i;
  assign bus_wr_rsp_valid_o   = wr_pend_q &&
                                (wr_clint_q ? clint_wr_rsp_valid_i : ext_wr_rsp_valid_i);
  assign clint_wr_rsp_ready_o = wr_pend_q && wr_clint_q && bus_wr_rsp_ready_i;
  assign ext_wr_rsp_ready_o   = wr_pend_q && !wr_clint_q && bus_wr_rsp_ready_i;
  assign wr_rsp_fire          = bus_wr_rsp_valid_o && bus_wr_rsp_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_pend_q  <= 1'b0;
      rd_clint_q <= 1'b0;
      wr_pend_q  <= 1'b0;
      wr_clint_q <= 1'b0;
    end else begin
      if (rd_fire) begin
        rd_pend_q  <= 1'b1;
        rd_clint_q <= rd_sel_clint;
      end else if (rd_rsp_fire) begin
        rd_pend_q <= 1'b0;
      end
      if (wr_fire) begin
        wr_pend_q  <= 1'b1;
        wr_clint_q <= wr_sel_clint;
      end else if (wr_rsp_fire) begin
        wr_pend_q <= 1'b0;
      end
    end
  end

  a_rd_target_stable : assert property (@(posedge clock) disable iff (reset)
    rd_pend_q && !rd_rsp_fire |=> $stable(rd_clint_q));

  a_wr_target_stable : assert property (@(posedge clock) disable iff (reset)
    wr_pend_q && !wr_rsp_fire |=> $stable(wr_clint_q));

endmodule

`default_nettype wire

//--- design/clint_timer.sv
`default_nettype none

module clint_timer (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire bus_pkg::rd_req_t  clint_rd_req_i,
  input  wire logic              clint_rd_valid_i,
  output logic                   clint_rd_ready_o,
  output bus_pkg::rd_rsp_t       clint_rd_rsp_o,
  output logic                   clint_rd_rsp_valid_o,
  input  wire logic              clint_rd_rsp_ready_i,
  input  wire bus_pkg::wr_req_t  clint_wr_req_i,
  input  wire logic              clint_wr_valid_i,
  output logic                   clint_wr_ready_o,
  output bus_pkg::wr_rsp_t       clint_wr_rsp_o,
  output logic                   clint_wr_rsp_valid_o,
  input  wire logic              clint_wr_rsp_ready_i
);

  bus_pkg::data_t mtime_q;
  bus_pkg::data_t rd_data_q;
  logic           rd_rsp_valid_q;
  logic           wr_rsp_valid_q;
  logic           rd_fire;
  logic           wr_fire;

  // one request in flight per channel
  assign clint_rd_ready_o = !rd_rsp_valid_q;
  assign clint_wr_ready_o = !wr_rsp_valid_q;
  assign rd_fire          = clint_rd_valid_i && clint_rd_ready_o;
  assign wr_fire          = clint_wr_valid_i && clint_wr_ready_o;

  assign clint_rd_rsp_o       = '{data: rd_data_q, resp: bus_pkg::RESP_OKAY};
  assign clint_rd_rsp_valid_o = rd_rsp_valid_q;
  // mtime is read only
  assign clint_wr_rsp_o       = '{resp: bus_pkg::RESP_SLVERR};
  assign clint_wr_rsp_valid_o = wr_rsp_valid_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_rsp_valid_q <= 1'b0;
      wr_rsp_valid_q <= 1'b0;
    end else begin
      if (rd_fire) begin
        rd_rsp_valid_q <= 1'b1;
      end else if (clint_rd_rsp_ready_i) begin
        rd_rsp_valid_q <= 1'b0;
      end
      if (wr_fire) begin
        wr_rsp_valid_q <= 1'b1;
      end else if (clint_wr_rsp_ready_i) begin
        wr_rsp_valid_q <= 1'b0;
      end
    end
  end

  // other offsets in the window read as zero
  always_ff @(posedge clock) begin
    if (rd_fire) begin
      rd_data_q <= (clint_rd_req_i.addr[15:0] == bus_pkg::MTIME_OFFSET) ? mtime_q : '0;
    end
  end

  a_rd_rsp_hold : assert property (@(posedge clock) disable iff (reset)
    clint_rd_rsp_valid_o && !clint_rd_rsp_ready_i |=> $stable(clint_rd_rsp_o));

endmodule

`default_nettype wire

//--- design/mem_fabric.sv
`default_nettype none

module mem_fabric (
  input  wire logic              clock,
  input  wire logic              reset,
  // instruction port
  input  wire bus_pkg::rd_req_t  inst_rd_req_i,
  input  wire logic              inst_rd_valid_i,
  output logic                   inst_rd_ready_o,
  output bus_pkg::rd_rsp_t       inst_rd_rsp_o,
  output logic                   inst_rd_rsp_valid_o,
  input  wire logic              inst_rd_rsp_ready_i,
  // data port
  input  wire bus_pkg::rd_req_t  data_rd_req_i,
  input  wire logic              data_rd_valid_i,
  output logic                   data_rd_ready_o,
  output bus_pkg::rd_rsp_t       data_rd_rsp_o,
  output logic                   data_rd_rsp_valid_o,
  input  wire logic              data_rd_rsp_ready_i,
  input  wire bus_pkg::wr_req_t  data_wr_req_i,
  input  wire logic              data_wr_valid_i,
  output logic                   data_wr_ready_o,
  output bus_pkg::wr_rsp_t       data_wr_rsp_o,
  output logic                   data_wr_rsp_valid_o,
  input  wire logic              data_wr_rsp_ready_i,
  // external master port
  output bus_pkg::rd_req_t       ext_rd_req_o,
  output logic                   ext_rd_valid_o,
  input  wire logic              ext_rd_ready_i,
  input  wire bus_pkg::rd_rsp_t  ext_rd_rsp_i,
  input  wire logic              ext_rd_rsp_valid_i,
  output logic                   ext_rd_rsp_ready_o,
  output bus_pkg::wr_req_t       ext_wr_req_o,
  output logic                   ext_wr_valid_o,
  input  wire logic              ext_wr_ready_i,
  input  wire bus_pkg::wr_rsp_t  ext_wr_rsp_i,
  input  wire logic              ext_wr_rsp_valid_i,
  output logic                   ext_wr_rsp_ready_o
);

  // arbiter to crossbar
  bus_pkg::rd_req_t bus_rd_req;
  logic             bus_rd_valid, bus_rd_ready;
  bus_pkg::rd_rsp_t bus_rd_rsp;
  logic             bus_rd_rsp_valid, bus_rd_rsp_ready;
  bus_pkg::wr_req_t bus_wr_req;
  logic             bus_wr_valid, bus_wr_ready;
  bus_pkg::wr_rsp_t bus_wr_rsp;
  logic             bus_wr_rsp_valid, bus_wr_rsp_ready;

  // crossbar to timer
  bus_pkg::rd_req_t clint_rd_req;
  logic             clint_rd_valid, clint_rd_ready;
  bus_pkg::rd_rsp_t clint_rd_rsp;
  logic             clint_rd_rsp_valid, clint_rd_rsp_ready;
  bus_pkg::wr_req_t clint_wr_req;
  logic             clint_wr_valid, clint_wr_ready;
  bus_pkg::wr_rsp_t clint_wr_rsp;
  logic             clint_wr_rsp_valid, clint_wr_rsp_ready;

  // port channels share names with the top level
  bus_arbiter i_bus_arbiter (
    .*,
    .bus_rd_req_o       (bus_rd_req),
    .bus_rd_valid_o     (bus_rd_valid),
    .bus_rd_ready_i     (bus_rd_ready),
    .bus_rd_rsp_i       (bus_rd_rsp),
    .bus_rd_rsp_valid_i (bus_rd_rsp_valid),
    .bus_rd_rsp_ready_o (bus_rd_rsp_ready),
    .bus_wr_req_o       (bus_wr_req),
    .bus_wr_valid_o     (bus_wr_valid),
    .bus_wr_ready_i     (bus_wr_ready),
    .bus_wr_rsp_i       (bus_wr_rsp),
    .bus_wr_rsp_valid_i (bus_wr_rsp_valid),
    .bus_wr_rsp_ready_o (bus_wr_rsp_ready)
  );

  bus_xbar i_bus_xbar (
    .*,
    .bus_rd_req_i         (bus_rd_req),
    .bus_rd_valid_i       (bus_rd_valid),
    .bus_rd_ready_o       (bus_rd_ready),
    .bus_rd_rsp_o         (bus_rd_rsp),
    .bus_rd_rsp_valid_o   (bus_rd_rsp_valid),
    .bus_rd_rsp_ready_i   (bus_rd_rsp_ready),
    .bus_wr_req_i         (bus_wr_req),
    .bus_wr_valid_i       (bus_wr_valid),
    .bus_wr_ready_o       (bus_wr_ready),
    .bus_wr_rsp_o         (bus_wr_rsp),
    .bus_wr_rsp_valid_o   (bus_wr_rsp_valid),
    .bus_wr_rsp_ready_i   (bus_wr_rsp_ready),
    .clint_rd_req_o       (clint_rd_req),
    .clint_rd_valid_o     (clint_rd_valid),
    .clint_rd_ready_i     (clint_rd_ready),
    .clint_rd_rsp_i       (clint_rd_rsp),
    .clint_rd_rsp_valid_i (clint_rd_rsp_valid),
    .clint_rd_rsp_ready_o (clint_rd_rsp_ready),
    .clint_wr_req_o       (clint_wr_req),
    .clint_wr_valid_o     (clint_wr_valid),
    .clint_wr_ready_i     (clint_wr_ready),
    .clint_wr_rsp_i       (clint_wr_rsp),
    .clint_wr_rsp_valid_i (clint_wr_rsp_valid),
    .clint_wr_rsp_ready_o (clint_wr_rsp_ready)
  );

  clint_timer i_clint_timer (
    .clock                (clock),
    .reset                (reset),
    .clint_rd_req_i       (clint_rd_req),
    .clint_rd_valid_i     (clint_rd_valid),
    .clint_rd_ready_o     (clint_rd_ready),
    .clint_rd_rsp_o       (clint_rd_rsp),
    .clint_rd_rsp_valid_o (clint_rd_rsp_valid),
    .clint_rd_rsp_ready_i (clint_rd_rsp_ready),
    .clint_wr_req_i       (clint_wr_req),
    .clint_wr_valid_i     (clint_wr_valid),
    .clint_wr_ready_o     (clint_wr_ready),
    .clint_wr_rsp_o       (clint_wr_rsp),
    .clint_wr_rsp_valid_o (clint_wr_rsp_valid),
    .clint_wr_rsp_ready_i (clint_wr_rsp_ready)
  );

endmodule

`default_nettype wire

//--- verif/tb_mem_fabric.sv
`default_nettype none

module tb_mem_fabric;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 100;

  logic clock = 1'b0;
  logic reset;
  int   seed = 32'h810b;
  int   errors;

  bus_pkg::rd_req_t inst_rd_req_i, data_rd_req_i, ext_rd_req_o;
  bus_pkg::rd_rsp_t inst_rd_rsp_o, data_rd_rsp_o, ext_rd_rsp_i;
  bus_pkg::wr_req_t data_wr_req_i, ext_wr_req_o;
  bus_pkg::wr_rsp_t data_wr_rsp_o, ext_wr_rsp_i;
  logic inst_rd_valid_i, inst_rd_ready_o, inst_rd_rsp_valid_o, inst_rd_rsp_ready_i;
  logic data_rd_valid_i, data_rd_ready_o, data_rd_rsp_valid_o, data_rd_rsp_ready_i;
  logic data_wr_valid_i, data_wr_ready_o, data_wr_rsp_valid_o, data_wr_rsp_ready_i;
  logic ext_rd_valid_o, ext_rd_ready_i, ext_rd_rsp_valid_i, ext_rd_rsp_ready_o;
  logic ext_wr_valid_o, ext_wr_ready_i, ext_wr_rsp_valid_i, ext_wr_rsp_ready_o;

  // external memory keyed by 8-byte word address
  bus_pkg::data_t mem [logic [28:0]];
  bus_pkg::addr_t ext_rd_log[$];
  int             ext_rd_count;
  int             ext_wr_count;

  // response hold tracking
  logic             inst_hold_q, data_hold_q, wr_hold_q;
  bus_pkg::rd_rsp_t inst_rsp_q, data_rsp_q;
  bus_pkg::wr_rsp_t wr_rsp_q;

  mem_fabric i_mem_fabric (.*);

  always #10 clock = ~clock;

  task automatic abort_run(input string what);
    $display("%s at %0t ns", what, $time);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    errors++;
  endtask

  function automatic bus_pkg::data_t mem_read(input bus_pkg::addr_t a);
    logic [31:0] wa;
    wa = {3'b000, a[31:3]};
    if (mem.exists(a[31:3])) begin
      return mem[a[31:3]];
    end
    return {~wa, wa};
  endfunction

  function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old_w,
                                                 input bus_pkg::data_t new_w,
                                                 input bus_pkg::strb_t strb);
    bus_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  // external read side
  initial begin : ext_read_model
    int             d;
    int             n;
    bus_pkg::addr_t a;
    forever begin
      @(posedge clock);
      if (!reset && ext_rd_valid_o) begin
        d = {$random(seed)} % 4;
        @(negedge clock);
        repeat (d) @(negedge clock);
        ext_rd_ready_i = 1'b1;
        @(posedge clock);
        a = ext_rd_req_o.addr;
        ext_rd_log.push_back(a);
        ext_rd_count++;
        d = {$random(seed)} % 4;
        @(negedge clock);
        ext_rd_ready_i = 1'b0;
        repeat (d) @(negedge clock);
        ext_rd_rsp_i = '{data: mem_read(a), resp: bus_pkg::RESP_OKAY};
        ext_rd_rsp_valid_i = 1'b1;
        n = 0;
        do begin
          @(posedge clock);
          n++;
          if (n > TIMEOUT) abort_run("external read response was never taken");
        end while (!ext_rd_rsp_ready_o);
        @(negedge clock);
        ext_rd_rsp_valid_i = 1'b0;
      end
    end
  end

  // external write side
  initial begin : ext_write_model
    int               d;
    int               n;
    bus_pkg::wr_req_t w;
    forever begin
      @(posedge clock);
      if (!reset && ext_wr_valid_o) begin
        d = {$random(seed)} % 4;
        @(negedge clock);
        repeat (d) @(negedge clock);
        ext_wr_ready_i = 1'b1;
        @(posedge clock);
        w = ext_wr_req_o;
        mem[w.addr[31:3]] = merge_bytes(mem_read(w.addr), w.data, w.strb);
        ext_wr_count++;
        d = {$random(seed)} % 4;
        @(negedge clock);
        ext_wr_ready_i = 1'b0;
        repeat (d) @(negedge clock);
        ext_wr_rsp_i = '{resp: bus_pkg::RESP_OKAY};
        ext_wr_rsp_valid_i = 1'b1;
        n = 0;
        do begin
          @(posedge clock);
          n++;
          if (n > TIMEOUT) abort_run("external write response was never taken");
        end while (!ext_wr_rsp_ready_o);
        @(negedge clock);
        ext_wr_rsp_valid_i = 1'b0;
      end
    end
  end

  // held responses stay put and the bus stays quiet meanwhile
  always @(posedge clock) begin
    if (!reset) begin
      if ((inst_rd_rsp_valid_o || data_rd_rsp_valid_o || data_wr_rsp_valid_o) &&
          (ext_rd_valid_o || ext_wr_valid_o)) begin
        report_mismatch("external request while a response is pending");
      end
      if (inst_hold_q && (!inst_rd_rsp_valid_o || inst_rd_rsp_o != inst_rsp_q)) begin
        report_mismatch("inst read response changed while held");
      end
      if (data_hold_q && (!data_rd_rsp_valid_o || data_rd_rsp_o != data_rsp_q)) begin
        report_mismatch("data read response changed while held");
      end
      if (wr_hold_q && (!data_wr_rsp_valid_o || data_wr_rsp_o != wr_rsp_q)) begin
        report_mismatch("write response changed while held");
      end
    end
    inst_hold_q <= !reset && inst_rd_rsp_valid_o && !inst_rd_rsp_ready_i;
    data_hold_q <= !reset && data_rd_rsp_valid_o && !data_rd_rsp_ready_i;
    wr_hold_q   <= !reset && data_wr_rsp_valid_o && !data_wr_rsp_ready_i;
    inst_rsp_q  <= inst_rd_rsp_o;
    data_rsp_q  <= data_rd_rsp_o;
    wr_rsp_q    <= data_wr_rsp_o;
  end

  task automatic read_beat(input logic [7:0] port, input bus_pkg::addr_t addr,
                           output bus_pkg::data_t data, output bus_pkg::resp_t resp);
    int n;
    int hold;
    logic is_data;
    is_data = (port == "D");
    @(negedge clock);
    if (is_data) begin
      data_rd_req_i.addr = addr;
      data_rd_valid_i = 1'b1;
    end else begin
      inst_rd_req_i.addr = addr;
      inst_rd_valid_i = 1'b1;
    end
    n = 0;
    do begin
      @(posedge clock);
      n++;
      if (n > TIMEOUT) abort_run("read request was never accepted");
    end while (!(is_data ? data_rd_ready_o : inst_rd_ready_o));
    @(negedge clock);
    if (is_data) data_rd_valid_i = 1'b0;
    else inst_rd_valid_i = 1'b0;
    // withhold ready a little
    hold = {$random(seed)} % 4;
    repeat (hold) @(negedge clock);
    if (is_data) data_rd_rsp_ready_i = 1'b1;
    else inst_rd_rsp_ready_i = 1'b1;
    n = 0;
    do begin
      @(posedge clock);
      n++;
      if (n > TIMEOUT) abort_run("read response never arrived");
    end while (!(is_data ? data_rd_rsp_valid_o : inst_rd_rsp_valid_o));
    data = is_data ? data_rd_rsp_o.data : inst_rd_rsp_o.data;
    resp = is_data ? data_rd_rsp_o.resp : inst_rd_rsp_o.resp;
    @(negedge clock);
    if (is_data) data_rd_rsp_ready_i = 1'b0;
    else inst_rd_rsp_ready_i = 1'b0;
  endtask

  task automatic write_beat(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                            input bus_pkg::strb_t strb, output bus_pkg::resp_t resp);
    int n;
    int hold;
    @(negedge clock);
    data_wr_req_i = '{addr: addr, data: data, strb: strb};
    data_wr_valid_i = 1'b1;
    n = 0;
    do begin
      @(posedge clock);
      n++;
      if (n > TIMEOUT) abort_run("write request was never accepted");
    end while (!data_wr_ready_o);
    @(negedge clock);
    data_wr_valid_i = 1'b0;
    hold = {$random(seed)} % 4;
    repeat (hold) @(negedge clock);
    data_wr_rsp_ready_i = 1'b1;
    n = 0;
    do begin
      @(posedge clock);
      n++;
      if (n > TIMEOUT) abort_run("write response never arrived");
    end while (!data_wr_rsp_valid_o);
    resp = data_wr_rsp_o.resp;
    @(negedge clock);
    data_wr_rsp_ready_i = 1'b0;
  endtask

  initial begin : watchdog
    #500000;
    abort_run("simulation ran too long");
  end

  initial begin : main
    int             fd, n, tests, failed, errs_before, rd_before, wr_before;
    string          line;
    logic [7:0]     port_c, op_c;
    bus_pkg::addr_t addr;
    bus_pkg::data_t wdata, exp_data, got, got_i;
    bus_pkg::strb_t strb;
    bus_pkg::resp_t exp_resp, resp, resp_i;
    bus_pkg::data_t last_mtime;
    logic           have_mtime, is_clint;
    errors = 0;
    tests = 0;
    failed = 0;
    have_mtime = 1'b0;
    reset = 1'b1;
    inst_rd_req_i = '0;
    inst_rd_valid_i = 1'b0;
    inst_rd_rsp_ready_i = 1'b0;
    data_rd_req_i = '0;
    data_rd_valid_i = 1'b0;
    data_rd_rsp_ready_i = 1'b0;
    data_wr_req_i = '0;
    data_wr_valid_i = 1'b0;
    data_wr_rsp_ready_i = 1'b0;
    ext_rd_ready_i = 1'b0;
    ext_rd_rsp_i = '0;
    ext_rd_rsp_valid_i = 1'b0;
    ext_wr_ready_i = 1'b0;
    ext_wr_rsp_i = '0;
    ext_wr_rsp_valid_i = 1'b0;
    ext_rd_count = 0;
    ext_wr_count = 0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(posedge clock);
    if (ext_rd_valid_o || ext_wr_valid_o || inst_rd_rsp_valid_o ||
        data_rd_rsp_valid_o || data_wr_rsp_valid_o) begin
      report_mismatch("valid output high after reset");
    end
    fd = $fopen("verif/bus_patterns.txt", "r");
    if (fd == 0) abort_run("could not open the pattern file");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%c %c %h %h %h %h %h", port_c, op_c, addr, wdata, strb,
                  exp_data, exp_resp);
      if (n != 7) continue;
      tests++;
      errs_before = errors;
      rd_before = ext_rd_count;
      wr_before = ext_wr_count;
      is_clint = (addr & bus_pkg::CLINT_MASK) == bus_pkg::CLINT_BASE;
      if (port_c == "B") begin
        // data read must reach the external port first
        fork
          read_beat("D", addr, got, resp);
          read_beat("I", addr + 32'd8, got_i, resp_i);
        join
        if (got != exp_data || resp != exp_resp) begin
          report_mismatch($sformatf("data read %h got %h/%0d", addr, got, resp));
        end
        if (got_i != wdata || resp_i != exp_resp) begin
          report_mismatch($sformatf("inst read %h got %h/%0d", addr + 8, got_i, resp_i));
        end
        if (ext_rd_count != rd_before + 2 || ext_rd_log[rd_before] != addr) begin
          report_mismatch("data read was not first on the external port");
        end
      end else if (op_c == "W") begin
        write_beat(addr, wdata, strb, resp);
        if (resp != exp_resp) begin
          report_mismatch($sformatf("write %h resp %0d, expected %0d", addr, resp, exp_resp));
        end
        if (ext_wr_count != wr_before + (is_clint ? 0 : 1)) begin
          report_mismatch("external write count wrong");
        end
      end else begin
        read_beat(port_c, addr, got, resp);
        if (resp != exp_resp) begin
          report_mismatch($sformatf("read %h resp %0d, expected %0d", addr, resp, exp_resp));
        end
        if (is_clint) begin
          if (ext_rd_count != rd_before) begin
            report_mismatch("timer read reached the external port");
          end
          if (have_mtime && got <= last_mtime) begin
            report_mismatch($sformatf("mtime %0d not above %0d", got, last_mtime));
          end
          last_mtime = got;
          have_mtime = 1'b1;
        end else if (got != exp_data) begin
          report_mismatch($sformatf("read %h got %h, expected %h", addr, got, exp_data));
        end
      end
      if (errors != errs_before) failed++;
      $display("test %0d %c%c %h: %s", tests, port_c, op_c, addr,
               (errors == errs_before) ? "ok" : "bad");
    end
    $fclose(fd);
    repeat (4) @(posedge clock);
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0 && tests > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
design/bus_pkg.sv
design/bus_arbiter.sv
design/bus_xbar.sv
design/clint_timer.sv
design/mem_fabric.sv
verif/tb_mem_fabric.sv

//--- verif/bus_patterns.txt
# port(I/D/B) op(R/W) addr wdata strb exp_data exp_resp, all hex
# B: data read at addr and inst read at addr+8 together, wdata holds the inst expected data
I R 80000000 0000000000000000 00 efffffff10000000 0
I R 80000008 0000000000000000 00 effffffe10000001 0
I R 80001230 0000000000000000 00 effffdb910000246 0
D W 80000100 1122334455667788 0f 0000000000000000 0
D R 80000100 0000000000000000 00 efffffdf55667788 0
D W 80000100 aabbccddeeff0011 c0 0000000000000000 0
D R 80000100 0000000000000000 00 aabbffdf55667788 0
D W 80000200 0123456789abcdef ff 0000000000000000 0
D R 80000200 0000000000000000 00 0123456789abcdef 0
D W 80000208 ffffffffffffffff 3c 0000000000000000 0
D R 80000208 0000000000000000 00 efffffffffff0041 0
B R 80000300 efffff9e10000061 00 efffff9f10000060 0
B R 80000400 efffff7e10000081 00 efffff7f10000080 0
D R 0200bff8 0000000000000000 00 0000000000000000 0
D R 0200bff8 0000000000000000 00 0000000000000000 0
I R 0200bff8 0000000000000000 00 0000000000000000 0
D W 0200bff8 0000000000000001 ff 0000000000000000 2
D W 02000000 0000000000000005 01 0000000000000000 2
D R 0200bff8 0000000000000000 00 0000000000000000 0
I R 80000100 0000000000000000 00 aabbffdf55667788 0
D R 80000200 0000000000000000 00 0123456789abcdef 0
